//--- common/mul_defines.svh
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// Width of the parallel multiplicand
`define MUL_OPERAND_W 16

// Width of the product and the running sum
`define MUL_PRODUCT_W 32

// Width of the shift amount and bit counter
// Covers shifts 0 to 15
`define MUL_SHIFT_W 4

`endif

//--- common/mul_pkg.sv
`default_nettype none

`include "mul_defines.svh"

package mul_pkg;

    // Sequencer states
    typedef enum logic [1:0] {
        ST_IDLE       = 2'd0,
        ST_ACCUMULATE = 2'd1,
        ST_DONE       = 2'd2
    } mul_state_e;

    // Partial-product opcodes
    // Subtract only for the sign bit of the multiplier
    typedef enum logic [1:0] {
        PP_ZERO = 2'd0,
        PP_ADD  = 2'd1,
        PP_SUB  = 2'd2
    } pp_op_e;

    // Signed product word
    typedef logic signed [`MUL_PRODUCT_W-1:0] product_t;

    // Decode to execute command
    typedef struct packed {
        pp_op_e                  op;
        logic [`MUL_SHIFT_W-1:0] shift;
    } pp_cmd_t;

    // Decode to result control
    typedef struct packed {
        logic enable;
        logic clear;
    } acc_ctrl_t;

endpackage

`default_nettype wire

//--- compile.f
+incdir+common
common/mul_pkg.sv
verilog/mul_sequencer.sv
verilog/partial_product_unit.sv
verilog/product_accumulator.sv
verilog/serial_multiplier.sv
verification/serial_multiplier_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the serial multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module serial_multiplier_tb \
    -Mdir obj_dir \
    -f compile.f

output="$(./obj_dir/Vserial_multiplier_tb)"
echo "$output"

if grep -q "=== PASS ===" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- verification/serial_multiplier_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module serial_multiplier_tb;

    import mul_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_ROWS  = 10;
    localparam int MAX_STALL    = 6;
    // Edges from acceptance to result_valid including the acceptance edge
    localparam int RESULT_EDGES = 17;
    // Longest wait on a handshake level
    localparam int WAIT_LIMIT   = 8;

    // One row of the stimulus table
    typedef struct packed {
        logic [`MUL_OPERAND_W-1:0] multiplicand;
        logic [`MUL_OPERAND_W-1:0] multiplier;
        logic [3:0]                stall;
        product_t                  expected;
    } entry_t;

    logic                      clk;
    logic                      reset;
    logic                      operand_valid;
    logic [`MUL_OPERAND_W-1:0] multiplicand;
    logic                      multiplier_bit;
    logic                      result_ready;
    logic                      operand_ready;
    logic                      result_valid;
    product_t                  product;
    logic                      end_of_transmission;

    entry_t entries[$];
    int     error_count = 0;
    int     pass_count  = 0;
    int     fail_count  = 0;
    longint watchdog_ns = 0;

    serial_multiplier dut0 (
        .clk                 (clk),
        .reset               (reset),
        .operand_valid       (operand_valid),
        .multiplicand        (multiplicand),
        .multiplier_bit      (multiplier_bit),
        .result_ready        (result_ready),
        .operand_ready       (operand_ready),
        .result_valid        (result_valid),
        .product             (product),
        .end_of_transmission (end_of_transmission)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks and table helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_product(input product_t actual, input product_t expected);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("ERROR product expected %h got %h at %0t", expected, actual, $time);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("ERROR %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count = error_count + 1;
        $display("%s at %0t", msg, $time);
    endtask

    // Expected value is the plain signed product of the two operands
    function automatic void add_entry(input logic [15:0] mc, input logic [15:0] mp,
                                      input logic [3:0] stall);
        entry_t e;
        e.multiplicand = mc;
        e.multiplier   = mp;
        e.stall        = stall;
        e.expected     = product_t'($signed(mc)) * product_t'($signed(mp));
        entries.push_back(e);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // One multiplication entered and left on a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic run_entry(input entry_t e);
        int waited;
        int edges;
        waited = 0;
        while (!operand_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!operand_ready) begin
            report_failure("operand_ready never rose");
            return;
        end
        // Start request for one cycle
        operand_valid = 1'b1;
        multiplicand  = e.multiplicand;
        @(posedge clk);
        edges = 1;
        // Serial multiplier bits LSB first
        for (int k = 0; k < `MUL_OPERAND_W; k++) begin
            @(negedge clk);
            operand_valid  = 1'b0;
            multiplier_bit = e.multiplier[k];
            check_flag(operand_ready, 1'b0, "operand_ready");
            check_flag(result_valid, 1'b0, "result_valid");
            check_flag(end_of_transmission, 1'b0, "end_of_transmission");
            @(posedge clk);
            edges++;
        end
        @(negedge clk);
        multiplier_bit = 1'b0;
        // Multiplicand is free once bit 15 is in
        multiplicand   = ~e.multiplicand;
        waited = 0;
        while (!result_valid && waited < WAIT_LIMIT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            waited++;
        end
        if (!result_valid) begin
            report_failure("result_valid never rose");
            return;
        end
        if (edges != RESULT_EDGES) begin
            report_failure($sformatf("result_valid rose %0d edges after acceptance, not %0d",
                                     edges, RESULT_EDGES));
        end
        check_product(product, e.expected);
        check_flag(operand_ready, 1'b0, "operand_ready");
        check_flag(end_of_transmission, 1'b0, "end_of_transmission");
        // Product must hold while the consumer stalls
        for (int s = 0; s < int'(e.stall); s++) begin
            @(posedge clk);
            @(negedge clk);
            check_flag(result_valid, 1'b1, "result_valid");
            check_flag(operand_ready, 1'b0, "operand_ready");
            check_flag(end_of_transmission, 1'b0, "end_of_transmission");
            check_product(product, e.expected);
        end
        // Take the product and look at the pulse mid cycle
        result_ready = 1'b1;
        #(CLK_PERIOD / 4);
        check_flag(end_of_transmission, 1'b1, "end_of_transmission");
        check_flag(result_valid, 1'b1, "result_valid");
        check_flag(operand_ready, 1'b0, "operand_ready");
        check_product(product, e.expected);
        @(posedge clk);
        @(negedge clk);
        result_ready = 1'b0;
        // Back in idle with a cleared sum
        check_flag(result_valid, 1'b0, "result_valid");
        check_flag(end_of_transmission, 1'b0, "end_of_transmission");
        check_flag(operand_ready, 1'b1, "operand_ready");
        check_product(product, '0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r_mc;
        logic [31:0] r_mp;
        logic [31:0] r_st;
        longint      cycles;
        int          errors_before;
        reset          = 1'b0;
        operand_valid  = 1'b0;
        multiplicand   = '0;
        multiplier_bit = 1'b0;
        result_ready   = 1'b0;
        void'($urandom(24));

        // Corner rows
        add_entry(16'h0000, 16'h0000, 4'd0);
        add_entry(16'h0001, 16'h0001, 4'd1);
        add_entry(16'hFFFF, 16'hFFFF, 4'd2);
        add_entry(16'h7FFF, 16'h7FFF, 4'd0);
        add_entry(16'h8000, 16'h8000, 4'd3);
        add_entry(16'h8000, 16'h7FFF, 4'd1);
        add_entry(16'h0003, 16'hFFFB, 4'd4);
        // Random rows
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            r_mc = $urandom;
            r_mp = $urandom;
            r_st = $urandom % MAX_STALL;
            add_entry(r_mc[15:0], r_mp[15:0], r_st[3:0]);
        end

        // Watchdog budget from the table
        cycles = RESET_CYCLES;
        foreach (entries[i]) begin
            cycles = cycles + 20 + longint'(entries[i].stall);
        end
        watchdog_ns = 2 * cycles * CLK_PERIOD;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        check_flag(operand_ready, 1'b1, "operand_ready");
        check_flag(result_valid, 1'b0, "result_valid");
        check_flag(end_of_transmission, 1'b0, "end_of_transmission");
        check_product(product, '0);

        for (int i = 0; i < entries.size(); i++) begin
            errors_before = error_count;
            run_entry(entries[i]);
            if (error_count == errors_before) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            $display("entry %0d: %0d x %0d = %0d, stall %0d, %s", i,
                     $signed(entries[i].multiplicand), $signed(entries[i].multiplier),
                     entries[i].expected, entries[i].stall,
                     (error_count == errors_before) ? "ok" : "wrong");
        end

        $display("entries ok %0d, wrong %0d, errors %0d", pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Ends a hung run
    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("Watchdog expired before all entries finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/mul_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module mul_sequencer (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          operand_valid,
    input  wire logic          multiplier_bit,
    input  wire logic          result_ready,
    output logic               operand_ready,
    output logic               result_valid,
    output logic               end_of_transmission,
    output mul_pkg::pp_cmd_t   pp_cmd,
    output mul_pkg::acc_ctrl_t acc_ctrl
);

    import mul_pkg::*;

    mul_state_e              state_q;
    mul_state_e              state_d;
    // Index of the multiplier bit sampled this cycle
    logic [`MUL_SHIFT_W-1:0] count_q;
    // High on the sign bit of the multiplier
    logic                    last_bit;

    //////////////////////////////////////////////////////////////////////
    // Handshake levels
    //////////////////////////////////////////////////////////////////////

    // Ready to take new operands only when idle
    assign operand_ready = (state_q == ST_IDLE);

    // Product waits in done until taken
    assign result_valid = (state_q == ST_DONE);

    // One cycle pulse when the product is taken
    assign end_of_transmission = result_valid && result_ready;

    // Counter all ones means bit 15
    assign last_bit = &count_q;

    //////////////////////////////////////////////////////////////////////
    // State and bit counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q <= ST_IDLE;
            count_q <= '0;
        end else begin
            state_q <= state_d;
            // Steps once per sampled bit, wraps back to 0 after bit 15
            if (state_q == ST_ACCUMULATE) begin
                count_q <= count_q + 1'b1;
            end else begin
                count_q <= '0;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // Start accepted on valid and ready together
                if (operand_valid && operand_ready) begin
                    state_d = ST_ACCUMULATE;
                end
            end
            ST_ACCUMULATE: begin
                // Sixteenth bit sampled at this edge
                if (last_bit) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                if (end_of_transmission) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Partial-product command and accumulator control
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Shift always follows the bit index
        pp_cmd.shift = count_q;
        pp_cmd.op    = PP_ZERO;
        if ((state_q == ST_ACCUMULATE) && multiplier_bit) begin
            // Weight of bit 15 is negative in two's complement
            pp_cmd.op = last_bit ? PP_SUB : PP_ADD;
        end
    end

    // Accumulate every bit, zero bits add nothing
    assign acc_ctrl.enable = (state_q == ST_ACCUMULATE);
    // Sum cleared at the same edge the product is taken
    assign acc_ctrl.clear  = end_of_transmission;

endmodule

`default_nettype wire

//--- verilog/partial_product_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module partial_product_unit (
    input  wire logic [`MUL_OPERAND_W-1:0] multiplicand,
    input  wire mul_pkg::pp_cmd_t          pp_cmd,
    output mul_pkg::product_t              partial
);

    import mul_pkg::*;

    // Multiplicand widened to product width
    product_t extended;
    // Zero, value or negated value before the shift
    product_t selected;

    //////////////////////////////////////////////////////////////////////
    // Sign extension
    //////////////////////////////////////////////////////////////////////

    // Replicate the sign bit into the upper half
    assign extended = {
        {(`MUL_PRODUCT_W - `MUL_OPERAND_W){multiplicand[`MUL_OPERAND_W-1]}},
        multiplicand
    };

    //////////////////////////////////////////////////////////////////////
    // Opcode select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (pp_cmd.op)
            PP_ADD: begin
                selected = extended;
            end
            PP_SUB: begin
                // Two's-complement negation
                selected = ~extended + 1'b1;
            end
            default: begin
                selected = '0;
            end
        endcase
    end

    // Bits shifted past the top drop out, sum wraps modulo 2^32
    assign partial = selected << pp_cmd.shift;

endmodule

`default_nettype wire

//--- verilog/product_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module product_accumulator (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire mul_pkg::acc_ctrl_t acc_ctrl,
    input  wire mul_pkg::product_t  partial,
    output mul_pkg::product_t       product
);

    //////////////////////////////////////////////////////////////////////
    // Running sum
    //////////////////////////////////////////////////////////////////////

    // Product output is the sum register itself
    // Clear wins over enable, the two never overlap in practice
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            product <= '0;
        end else if (acc_ctrl.clear) begin
            // Ready for the next operand pair
            product <= '0;
        end else if (acc_ctrl.enable) begin
            // Wraps modulo 2^32
            product <= product + partial;
        end
    end

endmodule

`default_nettype wire

//--- verilog/serial_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module serial_multiplier (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      operand_valid,
    input  wire logic [`MUL_OPERAND_W-1:0] multiplicand,
    input  wire logic                      multiplier_bit,
    input  wire logic                      result_ready,
    output logic                           operand_ready,
    output logic                           result_valid,
    output mul_pkg::product_t              product,
    output logic                           end_of_transmission
);

    import mul_pkg::*;

    // Decode to execute
    pp_cmd_t   pp_cmd;
    // Decode to result
    acc_ctrl_t acc_ctrl;
    // Execute to result
    product_t  partial;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    mul_sequencer u_sequencer (
        .clk                 (clk),
        .reset               (reset),
        .operand_valid       (operand_valid),
        .multiplier_bit      (multiplier_bit),
        .result_ready        (result_ready),
        .operand_ready       (operand_ready),
        .result_valid        (result_valid),
        .end_of_transmission (end_of_transmission),
        .pp_cmd              (pp_cmd),
        .acc_ctrl            (acc_ctrl)
    );

    //////////////////////////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////////////////////////

    // Multiplicand used straight from the port, held stable by the source
    partial_product_unit u_partial_product (
        .multiplicand (multiplicand),
        .pp_cmd       (pp_cmd),
        .partial      (partial)
    );

    //////////////////////////////////////////////////////////////////////
    // Result
    //////////////////////////////////////////////////////////////////////

    product_accumulator u_accumulator (
        .clk      (clk),
        .reset    (reset),
        .acc_ctrl (acc_ctrl),
        .partial  (partial),
        .product  (product)
    );

endmodule

`default_nettype wire
